/* Bender.yml */
package:
  name: x300_radio_core

sources:
  # packages first, then the interface and the modules that use it
  - design/radio_cfg_pkg.sv
  - design/radio_regs_pkg.sv
  - design/settings_bus_if.sv
  - design/db_control.sv
  - design/fe_control.sv
  - design/radio_io_map.sv
  - design/x300_radio_core.sv
  - target: simulation
    files:
      - bench/tb_x300_radio_core.sv

/* bench/tb_x300_radio_core.sv */
module tb_x300_radio_core import radio_cfg_pkg::*, radio_regs_pkg::*; ();

   localparam int CLK_PERIOD  = 8;
   localparam int DRAIN_LIMIT = 64;   // cycles allowed for queued outputs
   localparam int STREAM_LEN  = 12;

   logic       radio_clk;
   logic       i_rst;
   logic       i_set_stb        [NUM_DBOARDS];
   set_addr_t  i_set_addr       [NUM_DBOARDS];
   word_t      i_set_data       [NUM_DBOARDS];
   logic       i_rb_stb         [NUM_DBOARDS];
   set_addr_t  i_rb_addr        [NUM_DBOARDS];
   word_t      o_rb_data        [NUM_DBOARDS];
   sample_t    i_rx             [NUM_DBOARDS];
   logic       i_rx_stb         [NUM_DBOARDS];
   sample_t    o_tx             [NUM_DBOARDS];
   logic       o_tx_stb         [NUM_DBOARDS];
   sample_t    o_rx_data        [NUM_CHANS];
   logic       o_rx_stb         [NUM_CHANS];
   sample_t    i_tx_data        [NUM_DBOARDS];
   logic       i_tx_stb         [NUM_DBOARDS];
   logic       i_rx_running     [NUM_CHANS];
   logic       i_tx_running     [NUM_CHANS];
   word_t      i_db_gpio_in     [NUM_DBOARDS];
   word_t      o_db_gpio_out    [NUM_DBOARDS];
   word_t      o_db_gpio_ddr    [NUM_DBOARDS];
   word_t      i_fp_gpio_in;
   word_t      i_radio_misc_in  [NUM_DBOARDS];
   word_t      o_radio_misc_out [NUM_DBOARDS];
   logic [2:0] o_radio_led      [NUM_DBOARDS];

   // scoreboard, entry is {tx, output index, sample}
   logic [35:0] exp_q [$];
   time         due_q [$];                  // strobe time of each entry
   iq_op_e      rx_op_m [NUM_CHANS];        // model of the fe opcode regs
   iq_op_e      tx_op_m [NUM_DBOARDS];
   word_t       gpio_m  [NUM_DBOARDS][4];   // atr words as written
   word_t       ddr_m   [NUM_DBOARDS];
   word_t       misc_m  [NUM_DBOARDS];

   string cur_test;
   int    test_errs;
   int    errors;
   int    checks;
   int    tests_run;
   int    tests_failed;
   bit    hung;                             // a drain timed out

   x300_radio_core u_dut (.*);

   initial begin
      radio_clk = 1'b0;
      forever #(CLK_PERIOD/2) radio_clk = ~radio_clk;
   end

   // ------------------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------------------

   function automatic int neg_clip(input int x);
      if (-x > 32767) begin
         return 32767;   // only -32768 lands here
      end
      return -x;
   endfunction

   function automatic sample_t ref_iq(input iq_op_e op, input sample_t s);
      int re;
      int im;
      int t;
      re = $signed(s[31:16]);
      im = $signed(s[15:0]);
      case (op)
         IQ_SWAP: begin
            t  = re;
            re = im;
            im = t;
         end
         IQ_CONJ: im = neg_clip(im);
         IQ_NEG: begin
            re = neg_clip(re);
            im = neg_clip(im);
         end
         default: ;
      endcase
      return {re[15:0], im[15:0]};
   endfunction

   // expected {leds, gpio} of one slot
   function automatic logic [34:0] ref_atr(input word_t w_idle, input word_t w_rx,
                                           input word_t w_tx, input word_t w_fdx,
                                           input logic rx, input logic tx);
      word_t g;
      case ({tx, rx})
         2'b00:   g = w_idle;
         2'b01:   g = w_rx;
         2'b10:   g = w_tx;
         default: g = w_fdx;
      endcase
      return {rx & tx, tx, rx & ~tx, g};
   endfunction

   function automatic word_t rb_expect(input int s, input set_addr_t a);
      case (a)
         RB_MISC_IN:    return i_radio_misc_in[s];
         RB_DB_GPIO_IN: return i_db_gpio_in[s];
         RB_FP_GPIO_IN: return i_fp_gpio_in;
         RB_GPIO_DDR:   return ddr_m[s];
         default:       return '0;
      endcase
   endfunction

   // first samples hit the -32768 corners
   function automatic sample_t pick_sample(input int k);
      case (k)
         0:       return {16'h8000, 16'($urandom)};
         1:       return {16'($urandom), 16'h8000};
         2:       return 32'h8000_8000;
         default: return $urandom;
      endcase
   endfunction

   // ------------------------------------------------------------------------
   // checking and bookkeeping
   // ------------------------------------------------------------------------

   task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
      checks++;
      assert (act === exp) else begin
         $display("Fail %s: %s expected %0h actual %0h", cur_test, what, exp, act);
         test_errs++;
      end
   endtask

   task automatic check_out(input bit is_tx, input int idx, input sample_t act);
      logic [35:0] e;
      time         due;
      assert (exp_q.size() != 0) else begin
         $display("%s: unexpected strobe on %s output %0d", cur_test, is_tx ? "tx" : "rx", idx);
         test_errs++;
      end
      if (exp_q.size() != 0) begin
         e   = exp_q.pop_front();
         due = due_q.pop_front();
         assert (e[35:32] == {is_tx, 3'(idx)}) else begin
            $display("%s: output %0d strobed out of order", cur_test, idx);
            test_errs++;
         end
         // one cycle after the input strobe
         assert ($time == due) else begin
            $display("%s: output %0d strobed at %0t, due at %0t", cur_test, idx, $time, due);
            test_errs++;
         end
         check_val(is_tx ? "tx sample" : "rx sample", e[31:0], act);
      end
   endtask

   // compare process, outputs settle well before the falling edge
   initial begin
      forever begin
         @(negedge radio_clk);
         for (int ch = 0; ch < NUM_CHANS; ch++) begin
            if (o_rx_stb[ch] === 1'b1) check_out(1'b0, ch, o_rx_data[ch]);
         end
         for (int s = 0; s < NUM_DBOARDS; s++) begin
            if (o_tx_stb[s] === 1'b1) check_out(1'b1, s, o_tx[s]);
         end
      end
   end

   task automatic start_test(input string name);
      cur_test  = name;
      test_errs = 0;
      tests_run++;
   endtask

   task automatic end_test();
      errors += test_errs;
      if (test_errs != 0) tests_failed++;
      $display("test %-9s %s, %0d errors", cur_test, (test_errs == 0) ? "ok" : "bad", test_errs);
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
         @(negedge radio_clk);
         n++;
      end
      assert (exp_q.size() == 0) else begin
         $display("%s: timed out, %0d outputs never came", cur_test, exp_q.size());
         test_errs++;
         hung = 1'b1;
         exp_q.delete();
         due_q.delete();
      end
   endtask

   // ------------------------------------------------------------------------
   // stimulus
   // ------------------------------------------------------------------------

   task automatic idle_inputs();
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         i_set_stb[s]       = 1'b0;
         i_set_addr[s]      = '0;
         i_set_data[s]      = '0;
         i_rb_stb[s]        = 1'b0;
         i_rb_addr[s]       = '0;
         i_rx[s]            = '0;
         i_rx_stb[s]        = 1'b0;
         i_tx_data[s]       = '0;
         i_tx_stb[s]        = 1'b0;
         i_db_gpio_in[s]    = '0;
         i_radio_misc_in[s] = '0;
      end
      for (int ch = 0; ch < NUM_CHANS; ch++) begin
         i_rx_running[ch] = 1'b0;
         i_tx_running[ch] = 1'b0;
      end
      i_fp_gpio_in = '0;
   endtask

   // one-cycle write strobe
   task automatic write_reg(input int s, input set_addr_t a, input word_t d);
      @(negedge radio_clk);
      i_set_stb[s]  = 1'b1;
      i_set_addr[s] = a;
      i_set_data[s] = d;
      @(negedge radio_clk);
      i_set_stb[s]  = 1'b0;
   endtask

   task automatic stream_rx(input int s, input int n);
      sample_t smp;
      int      ch;
      for (int k = 0; k < n; k++) begin
         @(negedge radio_clk);
         smp         = pick_sample(k);
         i_rx[s]     = smp;
         i_rx_stb[s] = 1'b1;
         for (int c = 0; c < NUM_CHANS_PER_DB; c++) begin
            ch = s * NUM_CHANS_PER_DB + c;   // same adc word on each channel
            exp_q.push_back({1'b0, 3'(ch), ref_iq(rx_op_m[ch], smp)});
            due_q.push_back($time + CLK_PERIOD);
         end
      end
      @(negedge radio_clk);
      i_rx_stb[s] = 1'b0;
   endtask

   task automatic stream_tx(input int s, input int n);
      sample_t smp;
      for (int k = 0; k < n; k++) begin
         @(negedge radio_clk);
         smp          = pick_sample(k);
         i_tx_data[s] = smp;
         i_tx_stb[s]  = 1'b1;
         exp_q.push_back({1'b1, 3'(s), ref_iq(tx_op_m[s], smp)});
         due_q.push_back($time + CLK_PERIOD);
      end
      @(negedge radio_clk);
      i_tx_stb[s] = 1'b0;
   endtask

   // readback one address, then check that the word holds
   task automatic read_back(input int s, input set_addr_t a);
      word_t     exp;
      set_addr_t idle_addr;
      @(negedge radio_clk);
      i_rb_stb[s]  = 1'b1;
      i_rb_addr[s] = a;
      exp          = rb_expect(s, a);
      @(negedge radio_clk);
      // no strobe, must be ignored, and reads differently from a
      idle_addr    = (a == RB_FP_GPIO_IN) ? RB_MISC_IN : RB_FP_GPIO_IN;
      i_rb_stb[s]  = 1'b0;
      i_rb_addr[s] = idle_addr;
      check_val($sformatf("readback %0d", a), exp, o_rb_data[s]);
      @(negedge radio_clk);
      check_val("readback hold", exp, o_rb_data[s]);
   endtask

   // ------------------------------------------------------------------------
   // tests
   // ------------------------------------------------------------------------

   task automatic test_reset();
      start_test("reset");
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         check_val("gpio out", 0, o_db_gpio_out[s]);
         check_val("gpio ddr", 0, o_db_gpio_ddr[s]);
         check_val("misc out", 0, o_radio_misc_out[s]);
         check_val("led", 0, o_radio_led[s]);
         check_val("tx stb", 0, o_tx_stb[s]);
         check_val("rb data", 0, o_rb_data[s]);
      end
      for (int ch = 0; ch < NUM_CHANS; ch++) begin
         check_val("rx stb", 0, o_rx_stb[ch]);
      end
      end_test();
   endtask

   task automatic test_atr();
      logic [34:0] exp;
      logic [3:0]  run [NUM_DBOARDS];
      start_test("atr_gpio");
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         for (int r = 0; r < 4; r++) begin
            gpio_m[s][r] = $urandom;
            write_reg(s, set_addr_t'(SR_DB_BASE + r), gpio_m[s][r]);
         end
         ddr_m[s] = $urandom;
         write_reg(s, GPIO_DDR, ddr_m[s]);
      end
      // run = {tx1, tx0, rx1, rx0}, each slot walks all 16 from its own offset
      for (int k = 0; k < 16; k++) begin
         for (int s = 0; s < NUM_DBOARDS; s++) begin
            run[s]              = 4'(k + 5 * s);
            i_rx_running[2*s]   = run[s][0];
            i_rx_running[2*s+1] = run[s][1];
            i_tx_running[2*s]   = run[s][2];
            i_tx_running[2*s+1] = run[s][3];
         end
         @(negedge radio_clk);
         for (int s = 0; s < NUM_DBOARDS; s++) begin
            exp = ref_atr(gpio_m[s][0], gpio_m[s][1], gpio_m[s][2], gpio_m[s][3],
                          run[s][0] | run[s][1], run[s][2] | run[s][3]);
            check_val("gpio out", exp[31:0], o_db_gpio_out[s]);
            check_val("led", exp[34:32], o_radio_led[s]);
            check_val("gpio ddr", ddr_m[s], o_db_gpio_ddr[s]);
         end
      end
      idle_inputs();
      end_test();
   endtask

   task automatic test_rx();
      int ch;
      start_test("rx_fe");
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         for (int c = 0; c < NUM_CHANS_PER_DB; c++) begin
            for (int op = 0; op < 4; op++) begin
               ch          = s * NUM_CHANS_PER_DB + c;
               rx_op_m[ch] = iq_op_e'(op);
               // junk in the upper bits, only [1:0] is the opcode
               write_reg(s, set_addr_t'(SR_RX_FE_BASE + c * SR_FE_CHAN_OFFSET),
                         ($urandom & ~32'h3) | op);
               stream_rx(s, STREAM_LEN);
               drain();
            end
         end
      end
      end_test();
   endtask

   task automatic test_tx();
      start_test("tx_fe");
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         for (int op = 0; op < 4; op++) begin
            tx_op_m[s] = iq_op_e'(op);
            write_reg(s, SR_TX_FE_BASE, ($urandom & ~32'h3) | op);
            stream_tx(s, STREAM_LEN);
            drain();
         end
      end
      end_test();
   endtask

   task automatic test_misc_rb();
      word_t v;
      set_addr_t rb_list [5];
      rb_list = '{RB_MISC_IN, RB_DB_GPIO_IN, RB_FP_GPIO_IN, RB_GPIO_DDR, RB_DB_BASE + 8'd4};
      start_test("misc_rb");
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         v = $urandom;
         write_reg(s, MISC_OUT, v);
         check_val("misc out early", misc_m[s], o_radio_misc_out[s]);   // one reg to go
         @(negedge radio_clk);
         misc_m[s] = v;
         check_val("misc out", misc_m[s], o_radio_misc_out[s]);
      end
      @(negedge radio_clk);
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         i_radio_misc_in[s] = $urandom;
         i_db_gpio_in[s]    = $urandom;
      end
      i_fp_gpio_in = $urandom;
      repeat (2) @(negedge radio_clk);   // misc in passes its input register
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         for (int i = 0; i < 5; i++) begin
            read_back(s, rb_list[i]);
         end
      end
      end_test();
   endtask

   // ------------------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------------------

   initial begin
      void'($urandom(32'h4742f32d));
      idle_inputs();
      for (int ch = 0; ch < NUM_CHANS; ch++) rx_op_m[ch] = IQ_PASS;
      for (int s = 0; s < NUM_DBOARDS; s++) begin
         tx_op_m[s] = IQ_PASS;
         ddr_m[s]   = '0;
         misc_m[s]  = '0;
      end
      i_rst = 1'b1;
      repeat (5) @(negedge radio_clk);
      i_rst = 1'b0;
      @(negedge radio_clk);
      test_reset();
      if (!hung) test_atr();
      if (!hung) test_rx();
      if (!hung) test_tx();
      if (!hung) test_misc_rb();
      $display("counts: %0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

/* design/db_control.sv */
module db_control import radio_cfg_pkg::*, radio_regs_pkg::*; (
   input  logic             radio_clk,
   input  logic             i_rst,
   settings_bus_if.periph   bus,
   input  logic             i_run_rx,      // any rx channel of the slot running
   input  logic             i_run_tx,      // any tx channel of the slot running
   input  word_t            i_misc_in,
   input  word_t            i_db_gpio_in,
   input  word_t            i_fp_gpio_in,
   output word_t            o_db_gpio_out,
   output word_t            o_db_gpio_ddr,
   output word_t            o_misc_out,
   output logic [2:0]       o_led          // {fdx, tx, rx only}
);

   // ------------------------------------------------------------------------
   // settings registers
   // ------------------------------------------------------------------------

   word_t      atr_gpio     [4];   // gpio value per atr state
   word_t      atr_gpio_nxt [4];
   word_t      gpio_ddr;
   word_t      misc_out;
   atr_state_e atr_state;

   // {tx, rx} maps straight onto the state encoding
   assign atr_state = atr_state_e'({i_run_tx, i_run_rx});

   // next value of the atr bank, so a write reaches the pins in one cycle
   always_comb begin
      atr_gpio_nxt = atr_gpio;
      if (bus.set_stb) begin
         case (bus.set_addr)
            GPIO_IDLE: atr_gpio_nxt[ATR_IDLE] = bus.set_data;
            GPIO_RX:   atr_gpio_nxt[ATR_RX]   = bus.set_data;
            GPIO_TX:   atr_gpio_nxt[ATR_TX]   = bus.set_data;
            GPIO_FDX:  atr_gpio_nxt[ATR_FDX]  = bus.set_data;
            default:   ;                      // not an atr reg
         endcase
      end
   end

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         for (int s = 0; s < 4; s++) begin
            atr_gpio[s] <= '0;
         end
         gpio_ddr <= '0;      // all pins input
         misc_out <= '0;
      end else begin
         atr_gpio <= atr_gpio_nxt;
         if (bus.set_stb) begin
            case (bus.set_addr)
               GPIO_DDR: gpio_ddr <= bus.set_data;
               MISC_OUT: misc_out <= bus.set_data;
               default:  ;
            endcase
         end
      end
   end

   assign o_db_gpio_ddr = gpio_ddr;
   assign o_misc_out    = misc_out;

   // ------------------------------------------------------------------------
   // atr driven gpio and leds
   // ------------------------------------------------------------------------

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_db_gpio_out <= '0;
         o_led         <= '0;
      end else begin
         o_db_gpio_out <= atr_gpio_nxt[atr_state];   // picks up same-cycle writes
         o_led[0]      <= i_run_rx & ~i_run_tx;      // rx only
         o_led[1]      <= i_run_tx;
         o_led[2]      <= (atr_state == ATR_FDX);
      end
   end

   // ------------------------------------------------------------------------
   // readback
   // ------------------------------------------------------------------------

   // loaded on rb_stb, held otherwise
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         bus.rb_data <= '0;
      end else if (bus.rb_stb) begin
         case (bus.rb_addr)
            RB_MISC_IN:    bus.rb_data <= i_misc_in;
            RB_DB_GPIO_IN: bus.rb_data <= i_db_gpio_in;
            RB_FP_GPIO_IN: bus.rb_data <= i_fp_gpio_in;
            RB_GPIO_DDR:   bus.rb_data <= gpio_ddr;
            default:       bus.rb_data <= '0;        // unmapped reads as zero
         endcase
      end
   end

endmodule

/* design/fe_control.sv */
module fe_control import radio_cfg_pkg::*, radio_regs_pkg::*; #(
   parameter int NUM_CHANS_PER_DB = 2
) (
   input  logic             radio_clk,
   input  logic             i_rst,
   settings_bus_if.listen   bus,
   input  sample_t          i_rx_data [NUM_CHANS_PER_DB],
   input  logic             i_rx_stb,                       // one strobe per slot
   output sample_t          o_rx_data [NUM_CHANS_PER_DB],
   output logic             o_rx_stb  [NUM_CHANS_PER_DB],
   input  sample_t          i_tx_data,
   input  logic             i_tx_stb,
   output sample_t          o_tx_data,
   output logic             o_tx_stb
);

   iq_op_e rx_op [NUM_CHANS_PER_DB];
   iq_op_e tx_op;

   // register address of rx channel ch
   function automatic set_addr_t rx_fe_addr(input int ch);
      return set_addr_t'(SR_RX_FE_BASE + ch * SR_FE_CHAN_OFFSET);
   endfunction

   // negate with clip, -32768 has no positive counterpart
   function automatic iq_t sat_neg(input iq_t x);
      return (x == IQ_MIN) ? IQ_MAX : iq_t'(-x);
   endfunction

   function automatic sample_t iq_apply(input iq_op_e op, input sample_t s);
      iq_t re;
      iq_t im;
      re = s[2*IQ_W-1:IQ_W];
      im = s[IQ_W-1:0];
      case (op)
         IQ_SWAP: return {im, re};
         IQ_CONJ: return {re, sat_neg(im)};
         IQ_NEG:  return {sat_neg(re), sat_neg(im)};
         default: return s;                           // pass
      endcase
   endfunction

   // ------------------------------------------------------------------------
   // opcode registers
   // ------------------------------------------------------------------------

   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         tx_op <= IQ_PASS;
         for (int c = 0; c < NUM_CHANS_PER_DB; c++) begin
            rx_op[c] <= IQ_PASS;
         end
      end else if (bus.set_stb) begin
         if (bus.set_addr == SR_TX_FE_BASE) begin
            tx_op <= iq_op_e'(bus.set_data[1:0]);   // upper bits ignored
         end
         for (int c = 0; c < NUM_CHANS_PER_DB; c++) begin
            if (bus.set_addr == rx_fe_addr(c)) begin
               rx_op[c] <= iq_op_e'(bus.set_data[1:0]);
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // one stage correction pipe
   // ------------------------------------------------------------------------

   // sample registers, only strobed samples are taken
   always_ff @(posedge radio_clk) begin
      for (int c = 0; c < NUM_CHANS_PER_DB; c++) begin
         if (i_rx_stb) begin
            o_rx_data[c] <= iq_apply(rx_op[c], i_rx_data[c]);
         end
      end
      if (i_tx_stb) begin
         o_tx_data <= iq_apply(tx_op, i_tx_data);
      end
   end

   // strobes ride along with the data
   always_ff @(posedge radio_clk) begin
      if (i_rst) begin
         o_tx_stb <= 1'b0;
         for (int c = 0; c < NUM_CHANS_PER_DB; c++) begin
            o_rx_stb[c] <= 1'b0;
         end
      end else begin
         o_tx_stb <= i_tx_stb;
         for (int c = 0; c < NUM_CHANS_PER_DB; c++) begin
            o_rx_stb[c] <= i_rx_stb;   // both channels share the adc strobe
         end
      end
   end

endmodule

/* design/radio_cfg_pkg.sv */
// ---------------------------------------------------------------------------
// radio core sizing and sample types
// ---------------------------------------------------------------------------

package radio_cfg_pkg;

   // slot and channel counts
   localparam int NUM_DBOARDS      = 2;
   localparam int NUM_CHANS_PER_DB = 2;  // rx channels per slot
   localparam int NUM_CHANS        = NUM_DBOARDS * NUM_CHANS_PER_DB;

   // widths
   localparam int IQ_W   = 16;           // one I or Q component
   localparam int WORD_W = 32;           // settings / gpio / misc words

   // one I or Q component, two's complement
   typedef logic [IQ_W-1:0] iq_t;

   // packed sample, I in the upper half and Q in the lower half
   typedef logic [2*IQ_W-1:0] sample_t;

   // register word for gpio, misc and readback
   typedef logic [WORD_W-1:0] word_t;

   // saturation limits of a component
   localparam iq_t IQ_MAX = {1'b0, {(IQ_W-1){1'b1}}};  // +32767
   localparam iq_t IQ_MIN = {1'b1, {(IQ_W-1){1'b0}}};  // -32768

endpackage

/* design/radio_io_map.sv */
module radio_io_map import radio_cfg_pkg::*; #(
   parameter int NUM_DBOARDS = 2
) (
   input  logic    radio_clk,
   input  logic    i_rst,
   input  sample_t i_rx             [NUM_DBOARDS],                    // adc word per slot
   output sample_t o_rx_chan        [NUM_DBOARDS*NUM_CHANS_PER_DB],
   input  logic    i_rx_running     [NUM_DBOARDS*NUM_CHANS_PER_DB],
   input  logic    i_tx_running     [NUM_DBOARDS*NUM_CHANS_PER_DB],
   output logic    o_run_rx         [NUM_DBOARDS],
   output logic    o_run_tx         [NUM_DBOARDS],
   input  word_t   i_misc_out       [NUM_DBOARDS],                    // from db_control
   output word_t   o_radio_misc_out [NUM_DBOARDS],                    // to the pins
   input  word_t   i_radio_misc_in  [NUM_DBOARDS],                    // from the pins
   output word_t   o_misc_in        [NUM_DBOARDS]                     // to readback
);

   // ------------------------------------------------------------------------
   // adc fan-out and atr aggregation
   // ------------------------------------------------------------------------

   // one adc word feeds every rx channel of its slot
   always_comb begin
      for (int d = 0; d < NUM_DBOARDS; d++) begin
         for (int c = 0; c < NUM_CHANS_PER_DB; c++) begin
            o_rx_chan[d*NUM_CHANS_PER_DB + c] = i_rx[d];
         end
      end
   end

   // slot is running if any of its channels is
   always_comb begin
      for (int d = 0; d < NUM_DBOARDS; d++) begin
         o_run_rx[d] = 1'b0;
         o_run_tx[d] = 1'b0;
         for (int c = 0; c < NUM_CHANS_PER_DB; c++) begin
            o_run_rx[d] = o_run_rx[d] | i_rx_running[d*NUM_CHANS_PER_DB + c];
            o_run_tx[d] = o_run_tx[d] | i_tx_running[d*NUM_CHANS_PER_DB + c];
         end
      end
   end

   // ------------------------------------------------------------------------
   // misc i/o registers, one stage each way
   // ------------------------------------------------------------------------

   always_ff @(posedge radio_clk) begin
      for (int d = 0; d < NUM_DBOARDS; d++) begin
         if (i_rst) begin
            o_radio_misc_out[d] <= '0;
            o_misc_in[d]        <= '0;
         end else begin
            o_radio_misc_out[d] <= i_misc_out[d];
            o_misc_in[d]        <= i_radio_misc_in[d];
         end
      end
   end

endmodule

/* design/radio_regs_pkg.sv */
// ---------------------------------------------------------------------------
// settings bus register map and encodings
// ---------------------------------------------------------------------------

package radio_regs_pkg;

   typedef logic [7:0] set_addr_t;

   // fixed register map bases
   localparam set_addr_t SR_DB_BASE        = 8'd160;
   localparam set_addr_t RB_DB_BASE        = 8'd16;
   localparam set_addr_t SR_FE_CHAN_OFFSET = 8'd16;              // stride per rx channel
   localparam set_addr_t SR_TX_FE_BASE     = SR_DB_BASE + 8'd48;
   localparam set_addr_t SR_RX_FE_BASE     = SR_DB_BASE + 8'd64;

   // daughterboard setting addresses
   typedef enum set_addr_t {
      GPIO_IDLE = SR_DB_BASE,
      GPIO_RX   = SR_DB_BASE + 8'd1,
      GPIO_TX   = SR_DB_BASE + 8'd2,
      GPIO_FDX  = SR_DB_BASE + 8'd3,
      GPIO_DDR  = SR_DB_BASE + 8'd4,
      MISC_OUT  = SR_DB_BASE + 8'd5
   } db_reg_e;

   // readback addresses
   typedef enum set_addr_t {
      RB_MISC_IN    = RB_DB_BASE,
      RB_DB_GPIO_IN = RB_DB_BASE + 8'd1,
      RB_FP_GPIO_IN = RB_DB_BASE + 8'd2,
      RB_GPIO_DDR   = RB_DB_BASE + 8'd3
   } db_rb_e;

   // front-end op, low two bits of a fe register
   typedef enum logic [1:0] {
      IQ_PASS = 2'd0,
      IQ_SWAP = 2'd1,   // exchange I and Q
      IQ_CONJ = 2'd2,   // negate Q
      IQ_NEG  = 2'd3    // negate both
   } iq_op_e;

   // encoding is {tx, rx}
   typedef enum logic [1:0] {
      ATR_IDLE = 2'd0,
      ATR_RX   = 2'd1,
      ATR_TX   = 2'd2,
      ATR_FDX  = 2'd3
   } atr_state_e;

endpackage

/* design/settings_bus_if.sv */
// per-slot settings bus, writes plus register readback
interface settings_bus_if import radio_cfg_pkg::*, radio_regs_pkg::*; ();

   logic      set_stb;    // one-cycle write strobe
   set_addr_t set_addr;
   word_t     set_data;

   logic      rb_stb;     // readback request
   set_addr_t rb_addr;
   word_t     rb_data;    // valid one cycle after rb_stb, held

   // register block with readback
   modport periph (
      input  set_stb, set_addr, set_data,
      input  rb_stb, rb_addr,
      output rb_data
   );

   // write-only listener
   modport listen (
      input  set_stb, set_addr, set_data
   );

endinterface

/* design/x300_radio_core.sv */
module x300_radio_core import radio_cfg_pkg::*, radio_regs_pkg::*; (
   input  logic      radio_clk,
   input  logic      i_rst,
   // settings buses, one per slot
   input  logic      i_set_stb        [NUM_DBOARDS],
   input  set_addr_t i_set_addr       [NUM_DBOARDS],
   input  word_t     i_set_data       [NUM_DBOARDS],
   input  logic      i_rb_stb         [NUM_DBOARDS],
   input  set_addr_t i_rb_addr        [NUM_DBOARDS],
   output word_t     o_rb_data        [NUM_DBOARDS],
   // adc / dac side
   input  sample_t   i_rx             [NUM_DBOARDS],
   input  logic      i_rx_stb         [NUM_DBOARDS],
   output sample_t   o_tx             [NUM_DBOARDS],
   output logic      o_tx_stb         [NUM_DBOARDS],
   // dsp side
   output sample_t   o_rx_data        [NUM_CHANS],
   output logic      o_rx_stb         [NUM_CHANS],
   input  sample_t   i_tx_data        [NUM_DBOARDS],
   input  logic      i_tx_stb         [NUM_DBOARDS],
   input  logic      i_rx_running     [NUM_CHANS],
   input  logic      i_tx_running     [NUM_CHANS],
   // daughterboard pins
   input  word_t     i_db_gpio_in     [NUM_DBOARDS],
   output word_t     o_db_gpio_out    [NUM_DBOARDS],
   output word_t     o_db_gpio_ddr    [NUM_DBOARDS],
   input  word_t     i_fp_gpio_in,                      // shared, readback only
   input  word_t     i_radio_misc_in  [NUM_DBOARDS],
   output word_t     o_radio_misc_out [NUM_DBOARDS],
   output logic [2:0] o_radio_led     [NUM_DBOARDS]
);

   sample_t rx_chan  [NUM_CHANS];     // adc word per channel
   logic    run_rx   [NUM_DBOARDS];
   logic    run_tx   [NUM_DBOARDS];
   word_t   misc_out [NUM_DBOARDS];   // db_control to pin register
   word_t   misc_in  [NUM_DBOARDS];   // registered pins to readback

   radio_io_map #(
      .NUM_DBOARDS      (NUM_DBOARDS)
   ) u_io_map (
      .radio_clk        (radio_clk),
      .i_rst            (i_rst),
      .i_rx             (i_rx),
      .o_rx_chan        (rx_chan),
      .i_rx_running     (i_rx_running),
      .i_tx_running     (i_tx_running),
      .o_run_rx         (run_rx),
      .o_run_tx         (run_tx),
      .i_misc_out       (misc_out),
      .o_radio_misc_out (o_radio_misc_out),
      .i_radio_misc_in  (i_radio_misc_in),
      .o_misc_in        (misc_in)
   );

   // ------------------------------------------------------------------------
   // per slot control and front end
   // ------------------------------------------------------------------------

   for (genvar s = 0; s < NUM_DBOARDS; s++) begin : g_slot
      settings_bus_if u_sbus ();
      sample_t fe_rx_in  [NUM_CHANS_PER_DB];
      sample_t fe_rx_out [NUM_CHANS_PER_DB];
      logic    fe_rx_stb [NUM_CHANS_PER_DB];

      assign u_sbus.set_stb  = i_set_stb[s];
      assign u_sbus.set_addr = i_set_addr[s];
      assign u_sbus.set_data = i_set_data[s];
      assign u_sbus.rb_stb   = i_rb_stb[s];
      assign u_sbus.rb_addr  = i_rb_addr[s];
      assign o_rb_data[s]    = u_sbus.rb_data;

      // slot local channel numbering
      for (genvar c = 0; c < NUM_CHANS_PER_DB; c++) begin : g_chan
         assign fe_rx_in[c]                       = rx_chan[s*NUM_CHANS_PER_DB + c];
         assign o_rx_data[s*NUM_CHANS_PER_DB + c] = fe_rx_out[c];
         assign o_rx_stb[s*NUM_CHANS_PER_DB + c]  = fe_rx_stb[c];
      end

      db_control u_db_control (
         .radio_clk     (radio_clk),
         .i_rst         (i_rst),
         .bus           (u_sbus.periph),
         .i_run_rx      (run_rx[s]),
         .i_run_tx      (run_tx[s]),
         .i_misc_in     (misc_in[s]),
         .i_db_gpio_in  (i_db_gpio_in[s]),
         .i_fp_gpio_in  (i_fp_gpio_in),
         .o_db_gpio_out (o_db_gpio_out[s]),
         .o_db_gpio_ddr (o_db_gpio_ddr[s]),
         .o_misc_out    (misc_out[s]),
         .o_led         (o_radio_led[s])
      );

      // tx of the slot's first channel drives the dac
      fe_control #(
         .NUM_CHANS_PER_DB (NUM_CHANS_PER_DB)
      ) u_fe_control (
         .radio_clk (radio_clk),
         .i_rst     (i_rst),
         .bus       (u_sbus.listen),
         .i_rx_data (fe_rx_in),
         .i_rx_stb  (i_rx_stb[s]),
         .o_rx_data (fe_rx_out),
         .o_rx_stb  (fe_rx_stb),
         .i_tx_data (i_tx_data[s]),
         .i_tx_stb  (i_tx_stb[s]),
         .o_tx_data (o_tx[s]),
         .o_tx_stb  (o_tx_stb[s])
      );
   end

endmodule

/* list.f */
design/radio_cfg_pkg.sv
design/radio_regs_pkg.sv
design/settings_bus_if.sv
design/db_control.sv
design/fe_control.sv
design/radio_io_map.sv
design/x300_radio_core.sv
bench/tb_x300_radio_core.sv
